/* design/pll_pkg.sv */
// shared constants for the reference-locked loop front end
// division ratios, lock and watchdog limits
// signed phase error type used by detector, monitor and top
package pll_pkg;

	// both inputs are divided to a common 16 kHz comparison rate
	localparam int ref_div = 625;		// 10 MHz reference strobes per tick
	localparam int vco_div = 768;		// 12.288 MHz VCXO strobes per tick
	localparam int div_cnt_width = 10;	// holds ratio-1 for either divider

	// phase error in ref_in cycles
	localparam int err_width = 16;

	// lock detection
	localparam int lock_window = 4;		// largest |error| still counted as in phase
	localparam int lock_count = 8;		// consecutive in-window comparisons for lock
	localparam int run_width = $clog2(lock_count + 1);	// run counter saturates at lock_count

	// reference watchdog
	localparam int ref_timeout = 2048;	// ref_in cycles with no ref_pulse before loss
	localparam int wd_width = $clog2(ref_timeout);	// counts 0 .. ref_timeout-1

	// positive means the reference edge came first
	typedef logic signed [err_width-1:0] phase_err_t;

endpackage

/* design/phase_if.sv */
// detector to monitor and drive signals
// ticks from the dividers, pump requests and measured phase error
`timescale 1ns/10ps

interface phase_if
	import pll_pkg::*;
();

	logic ref_tick;			// divided reference, one cycle wide
	logic vco_tick;			// divided VCXO, one cycle wide
	logic up;			// pump up request, reference leads
	logic down;			// pump down request, VCXO leads
	phase_err_t phase_err;		// signed cycles between paired ticks
	logic err_valid;		// phase_err is new this cycle

	// phase detector consumes both ticks and produces the rest
	modport det (
		input ref_tick,
		input vco_tick,
		output up,
		output down,
		output phase_err,
		output err_valid
	);

	modport mon (input phase_err, input err_valid);	// lock monitor only looks at errors

	modport drv (input up, input down, input vco_tick);	// vco_tick feeds the hold wave

endinterface

/* design/edge_divider.sv */
// strobe divider
// counts single-cycle input strobes and emits one registered tick
// every ratio strobes
`timescale 1ns/10ps

module edge_divider
	import pll_pkg::*;
#(
	parameter int ratio = ref_div		// strobes per output tick
)
(
	input logic ref_in,
	input logic osc_16k,
	input logic pulse,			// one strobe per input edge
	output logic tick			// one cycle wide, every ratio strobes
);

	logic [div_cnt_width-1:0] cnt;		// strobes seen since the last tick
	logic last_strobe;			// this strobe completes the ratio

	assign last_strobe = pulse && (cnt == div_cnt_width'(ratio - 1));

	always_ff @(posedge ref_in or posedge osc_16k)
	begin
		if (osc_16k)
		begin
			cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= last_strobe;		// registered, so one cycle after the strobe
			if (last_strobe)
			begin
				cnt <= '0;		// wrap for the next period
			end
			else if (pulse)
			begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

/* design/phase_detector.sv */
// tri-state phase frequency detector
// idle, ref_lead and vco_lead states drive the pump up/down requests
// a lag counter gives the signed phase error when the second tick arrives
`timescale 1ns/10ps

module phase_detector
	import pll_pkg::*;
(
	input logic ref_in,
	input logic osc_16k,
	phase_if.det pif
);

	typedef enum logic [1:0] {
		st_idle,			// waiting for the first tick of a pair
		st_ref_lead,			// reference arrived first, pumping up
		st_vco_lead			// VCXO arrived first, pumping down
	} det_state_t;

	det_state_t state;
	logic [err_width-2:0] cnt;		// cycles since the leading tick, saturates
	phase_err_t lag;			// counter as a positive error

	assign lag = phase_err_t'({1'b0, cnt});

	// pump requests follow the state directly so they rise one cycle after the tick
	assign pif.up = (state == st_ref_lead);
	assign pif.down = (state == st_vco_lead);

	always_ff @(posedge ref_in or posedge osc_16k)
	begin
		if (osc_16k)
		begin
			state <= st_idle;
			cnt <= '0;
			pif.phase_err <= '0;
			pif.err_valid <= 1'b0;
		end
		else
		begin
			pif.err_valid <= 1'b0;		// strobe, default low
			case (state)
				st_idle:
				begin
					if (pif.ref_tick && pif.vco_tick)
					begin
						pif.phase_err <= '0;	// coincident ticks, zero error and no pump
						pif.err_valid <= 1'b1;
					end
					else if (pif.ref_tick)
					begin
						state <= st_ref_lead;
						cnt <= (err_width-1)'(1);
					end
					else if (pif.vco_tick)
					begin
						state <= st_vco_lead;
						cnt <= (err_width-1)'(1);
					end
				end
				st_ref_lead:
				begin
					if (pif.vco_tick)	// lagging edge closes the pair
					begin
						state <= st_idle;
						pif.phase_err <= lag;		// reference led, positive
						pif.err_valid <= 1'b1;
					end
					else if (!(&cnt))
					begin
						cnt <= cnt + 1'b1;	// extra ref ticks are ignored here
					end
				end
				st_vco_lead:
				begin
					if (pif.ref_tick)
					begin
						state <= st_idle;
						pif.phase_err <= -lag;		// VCXO led, negative
						pif.err_valid <= 1'b1;
					end
					else if (!(&cnt))
					begin
						cnt <= cnt + 1'b1;
					end
				end
				default:
				begin
					state <= st_idle;	// unused encoding
				end
			endcase
		end
	end

endmodule

/* design/lock_monitor.sv */
// reference presence watchdog and lock detector
// watchdog is reloaded by every ref_pulse and expires after ref_timeout cycles
// lock needs lock_count consecutive errors within lock_window
`timescale 1ns/10ps

module lock_monitor
	import pll_pkg::*;
(
	input logic ref_in,
	input logic osc_16k,
	input logic ref_pulse,			// raw reference strobe, not divided
	phase_if.mon pif,
	output logic ref_present,		// high while reference strobes keep coming
	output logic locked			// high when the loop is in phase
);

	logic [wd_width-1:0] wd_cnt;		// cycles since the last ref_pulse
	logic wd_expired;
	logic [err_width-1:0] err_mag;		// |phase_err|, unsigned so -32768 fits
	logic in_window;
	logic [run_width-1:0] run_cnt;		// consecutive in-window comparisons
	logic lock_reg;

	assign wd_expired = (wd_cnt == wd_width'(ref_timeout - 1));

	// watchdog
	always_ff @(posedge ref_in or posedge osc_16k)
	begin
		if (osc_16k)
		begin
			wd_cnt <= '0;
			ref_present <= 1'b0;		// absent until the first strobe
		end
		else if (ref_pulse)
		begin
			wd_cnt <= '0;			// reload
			ref_present <= 1'b1;
		end
		else if (wd_expired)
		begin
			ref_present <= 1'b0;		// counter parks here until the next strobe
		end
		else
		begin
			wd_cnt <= wd_cnt + 1'b1;
		end
	end

	assign err_mag = pif.phase_err[err_width-1] ? -pif.phase_err : pif.phase_err;
	assign in_window = (err_mag <= err_width'(lock_window));

	// run counter and lock flag, updated on each comparison
	always_ff @(posedge ref_in or posedge osc_16k)
	begin
		if (osc_16k)
		begin
			run_cnt <= '0;
			lock_reg <= 1'b0;
		end
		else if (!ref_present)
		begin
			run_cnt <= '0;			// start over once the reference returns
			lock_reg <= 1'b0;
		end
		else if (pif.err_valid)
		begin
			if (!in_window)
			begin
				run_cnt <= '0;		// one bad comparison drops lock
				lock_reg <= 1'b0;
			end
			else
			begin
				if (run_cnt != run_width'(lock_count))
				begin
					run_cnt <= run_cnt + 1'b1;	// saturating
				end
				if (run_cnt >= run_width'(lock_count - 1))
				begin
					lock_reg <= 1'b1;	// this error completes the run
				end
			end
		end
	end

	// no lock claimed without a reference, even in the cycle it is lost
	assign locked = lock_reg && ref_present;

endmodule

/* design/loop_drive.sv */
// charge pump output stage
// passes the detector up/down requests while the reference is present,
// otherwise a VCXO derived square wave holds the loop filter at mid-scale
`timescale 1ns/10ps

module loop_drive
(
	input logic ref_in,
	input logic osc_16k,
	input logic ref_present,		// from the lock monitor watchdog
	phase_if.drv pif,
	output logic pump_up,
	output logic pump_dn
);

	logic hold_wave;			// 50% duty, toggles on every VCXO tick
	logic up_sel;
	logic dn_sel;

	always_ff @(posedge ref_in or posedge osc_16k)
	begin
		if (osc_16k)
		begin
			hold_wave <= 1'b0;
		end
		else if (pif.vco_tick)
		begin
			hold_wave <= ~hold_wave;	// free running, ready whenever the reference drops
		end
	end

	// output select
	assign up_sel = ref_present ? pif.up : hold_wave;
	assign dn_sel = ref_present && pif.down;	// down is idle during hold

	// registered so the pump pins never glitch at a mux change
	always_ff @(posedge ref_in or posedge osc_16k)
	begin
		if (osc_16k)
		begin
			pump_up <= 1'b0;
			pump_dn <= 1'b0;
		end
		else
		begin
			pump_up <= up_sel;
			pump_dn <= dn_sel;
		end
	end

endmodule

/* design/pfd_top.sv */
// top of the phase frequency detector front end
// two strobe dividers, detector, lock monitor and pump drive
// joined through one phase_if
`timescale 1ns/10ps

module pfd_top
	import pll_pkg::*;
(
	input logic ref_in,			// system clock
	input logic osc_16k,			// asynchronous reset, active high
	input logic ref_pulse,			// one strobe per reference edge
	input logic vco_pulse,			// one strobe per VCXO edge
	output logic pump_up,
	output logic pump_dn,
	output logic ref_present,
	output logic locked,
	output phase_err_t phase_err,
	output logic err_valid
);

	phase_if pif ();

	// 10 MHz reference down to 16 kHz
	edge_divider #(
		.ratio(ref_div)
	) i_ref_div (
		.ref_in(ref_in),
		.osc_16k(osc_16k),
		.pulse(ref_pulse),
		.tick(pif.ref_tick)
	);

	// 12.288 MHz VCXO down to 16 kHz
	edge_divider #(
		.ratio(vco_div)
	) i_vco_div (
		.ref_in(ref_in),
		.osc_16k(osc_16k),
		.pulse(vco_pulse),
		.tick(pif.vco_tick)
	);

	phase_detector i_det (
		.ref_in(ref_in),
		.osc_16k(osc_16k),
		.pif(pif.det)
	);

	lock_monitor i_mon (
		.ref_in(ref_in),
		.osc_16k(osc_16k),
		.ref_pulse(ref_pulse),		// watchdog sees every edge, not just ticks
		.pif(pif.mon),
		.ref_present(ref_present),
		.locked(locked)
	);

	loop_drive i_drv (
		.ref_in(ref_in),
		.osc_16k(osc_16k),
		.ref_present(ref_present),
		.pif(pif.drv),
		.pump_up(pump_up),
		.pump_dn(pump_dn)
	);

	// measured error straight from the detector
	assign phase_err = pif.phase_err;
	assign err_valid = pif.err_valid;

endmodule

/* tb/pfd_tb.sv */
// testbench for the phase frequency detector front end
// strobe generator driven from the golden file, cycle model of dividers,
// detector pairing, pump pulse widths and the hold square wave
`timescale 1ns/10ps

module pfd_tb
	import pll_pkg::*;
;

	logic ref_in;
	logic osc_16k;
	logic ref_pulse;
	logic vco_pulse;
	logic pump_up;
	logic pump_dn;
	logic ref_present;
	logic locked;
	phase_err_t phase_err;
	logic err_valid;

	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int tests = 0;
	int ref_gap = 0;			// cycles between strobes, 0 means absent
	int vco_gap = 0;
	int jit = 0;				// add one cycle of LFSR jitter to vco gaps
	int ref_cnt = 0;			// countdown to the next strobe
	int vco_cnt = 0;
	int ref_seen = 0;			// strobes since the last predicted tick
	int vco_seen = 0;
	int det_state = 0;			// 0 idle, 1 ref led, 2 vco led
	longint n = 0;				// model cycle index
	longint lead_t;				// index of the leading tick
	int exp_q[$];				// predicted phase errors in order
	logic [31:0] lfsr = 32'hd174ab37;
	logic hold_now = 0;			// predicted hold wave and its delay line
	logic h1 = 0;
	logic h2 = 0;
	logic h3 = 0;
	logic rp_prev = 0;
	int up_cnt = 0;				// pump cycles seen in the current comparison
	int dn_cnt = 0;
	bit pump_ok = 1;			// counts are usable for the pending comparison

	pfd_top i_dut (
		.ref_in(ref_in),
		.osc_16k(osc_16k),
		.ref_pulse(ref_pulse),
		.vco_pulse(vco_pulse),
		.pump_up(pump_up),
		.pump_dn(pump_dn),
		.ref_present(ref_present),
		.locked(locked),
		.phase_err(phase_err),
		.err_valid(err_valid)
	);

	initial
	begin
		ref_in = 1'b0;
		forever #2 ref_in = ~ref_in;	// 4 ns period
	end

	// fibonacci LFSR, taps 32 22 2 1, one step per bit taken
	function automatic bit take_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	// count a failed check and print its line
	task automatic report_error(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	// single bit output against its expected level
	task automatic check_bit(input string sig, input logic got, input logic want);
		checks++;
		assert (got === want)
			else report_error($sformatf("MISMATCH %s: got %h expected %h", sig, got, want));
	endtask

	// lag counter saturates at the top of its 15 bit range
	task automatic close_pair(input longint diff);
		longint mag;
		mag = (diff < 0) ? -diff : diff;
		if (mag > 32767)
			mag = 32767;
		exp_q.push_back((diff < 0) ? -int'(mag) : int'(mag));
		det_state = 0;
	endtask

	// detector pairing, ticks numbered by the cycle of their final strobe
	task automatic tick_event(input bit rt, input bit vt);
		case (det_state)
			0:
			begin
				if (rt && vt)
					exp_q.push_back(0);		// coincident, zero error
				else if (rt || vt)
				begin
					det_state = rt ? 1 : 2;
					lead_t = n;
				end
			end
			1: if (vt) close_pair(n - lead_t);	// extra ref ticks ignored
			2: if (rt) close_pair(lead_t - n);
		endcase
	endtask

	// one cycle: sample at the falling edge, check, then drive the next strobes
	task automatic step_cycle();
		int e;
		bit rs;
		bit vs;
		bit rt;
		bit vt;
		@(negedge ref_in);
		n++;
		up_cnt += pump_up;
		dn_cnt += pump_dn;
		if (err_valid)
		begin
			checks++;
			assert (exp_q.size() != 0)
				else report_error("err_valid pulsed with no comparison predicted");
			if (exp_q.size() != 0)
			begin
				e = exp_q.pop_front();
				checks++;
				assert (phase_err == phase_err_t'(e))
					else report_error($sformatf("MISMATCH phase_err: got %h expected %h",
						phase_err, e[15:0]));
				if (pump_ok)
				begin
					checks += 2;
					assert (up_cnt == ((e > 0) ? e : 0))
						else report_error($sformatf(
							"MISMATCH pump_up cycles: got %h expected %h", up_cnt, e));
					assert (dn_cnt == ((e < 0) ? -e : 0))
						else report_error($sformatf(
							"MISMATCH pump_dn cycles: got %h expected %h", dn_cnt, -e));
				end
			end
			up_cnt = 0;
			dn_cnt = 0;
			pump_ok = 1;
		end
		if (!ref_present && det_state != 0)
			pump_ok = 0;			// hold mode mixes into this comparison
		h3 = h2;
		h2 = h1;
		h1 = hold_now;
		if (!rp_prev)
		begin
			check_bit("pump_dn in hold", pump_dn, 1'b0);
			check_bit("pump_up in hold", pump_up, h3);
		end
		rp_prev = ref_present;
		rs = 0;
		vs = 0;
		if (ref_gap != 0)
		begin
			rs = (ref_cnt == 0);
			ref_cnt = rs ? ref_gap - 1 : ref_cnt - 1;
		end
		if (vco_gap != 0)
		begin
			vs = (vco_cnt == 0);
			if (vs)
				vco_cnt = vco_gap - 1 + ((jit != 0) ? int'(take_bit()) : 0);
			else
				vco_cnt--;
		end
		ref_pulse = rs;
		vco_pulse = vs;
		ref_seen += rs;
		vco_seen += vs;
		rt = (ref_seen == ref_div);
		vt = (vco_seen == vco_div);
		if (rt)
			ref_seen = 0;
		if (vt)
		begin
			vco_seen = 0;
			hold_now = ~hold_now;		// hold wave toggles per vco tick
		end
		tick_event(rt, vt);
	endtask

	task automatic run_row(input logic [8*16-1:0] name, input int rg, input int vg,
			input int skew, input int jt, input int cycles, input int e_rp,
			input int e_lk, input int e_sign);
		int t;
		int sgn;
		test_errors = 0;
		if (ref_gap == 0 && rg != 0)
			ref_cnt = skew;			// first strobe after skew cycles
		if (vco_gap == 0 && vg != 0)
			vco_cnt = 0;
		ref_gap = rg;
		vco_gap = vg;
		jit = jt;
		for (t = 0; t < cycles; t++)
			step_cycle();
		for (t = 0; t < 8 && exp_q.size() != 0; t++)
			step_cycle();			// let a closing pair report
		checks++;
		assert (exp_q.size() == 0)
			else report_error("timeout waiting for err_valid of a predicted comparison");
		check_bit("ref_present", ref_present, e_rp[0]);
		check_bit("locked", locked, e_lk[0]);
		sgn = (phase_err > 0) ? 1 : ((phase_err < 0) ? -1 : 0);
		checks++;
		assert (e_sign == 9 || sgn == e_sign)
			else report_error($sformatf("MISMATCH phase_err sign: got %h expected %h",
				sgn, e_sign));
		tests++;
		$display("test %0s: %0s, %0d errors", name, (test_errors == 0) ? "ok" : "failed",
			test_errors);
	endtask

	initial
	begin
		#10_000_000;
		$display("simulation time limit reached");
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		int fd;
		int code;
		int rg, vg, skew, jt, cyc, e_rp, e_lk, e_sign;
		logic [8*16-1:0] name;
		logic [8*200-1:0] dummy;
		osc_16k = 1'b1;
		ref_pulse = 1'b0;
		vco_pulse = 1'b0;
		repeat (16) @(posedge ref_in);
		@(negedge ref_in);
		osc_16k = 1'b0;
		@(negedge ref_in);
		// everything idle straight out of reset
		check_bit("pump_up", pump_up, 1'b0);
		check_bit("pump_dn", pump_dn, 1'b0);
		check_bit("locked", locked, 1'b0);
		check_bit("err_valid", err_valid, 1'b0);
		check_bit("ref_present", ref_present, 1'b0);
		fd = $fopen("tb/pfd_golden.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the golden file");
			errors++;
		end
		while (fd != 0)
		begin
			code = $fscanf(fd, "%s", name);
			if (code != 1)
				break;
			if (name == "#")
			begin
				code = $fgets(dummy, fd);	// skip comment text
				continue;
			end
			code = $fscanf(fd, "%d %d %d %d %d %d %d %d", rg, vg, skew, jt, cyc,
				e_rp, e_lk, e_sign);
			if (code != 8)
			begin
				$display("malformed row in the golden file");
				errors++;
				break;
			end
			run_row(name, rg, vg, skew, jt, cyc, e_rp, e_lk, e_sign);
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0 && tests > 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* tb/pfd_golden.txt */
# columns: name ref_gap vco_gap ref_skew jitter cycles ref_present locked err_sign
# gaps in cycles between strobes (0 absent), err_sign 9 means not checked
# 145*625 and 118*768 cycles differ by one, so the error drifts by one per comparison
# ref_skew 22 makes the first error +4, lock comes after the eighth comparison
reset   0   0   0   0   10       0   0   0
match   145 118 22  0   760000   1   1   -1
# drift past the window, error reaches -5 and lock drops
drift   145 118 0   0   200000   1   0   -1
jitter  145 118 0   1   300000   1   0   1
# reference gone, watchdog expires and the hold wave takes over
lost    0   118 0   0   200000   0   0   1
resume  145 118 0   0   300000   1   0   9

/* flist.f */
design/pll_pkg.sv
design/phase_if.sv
design/edge_divider.sv
design/phase_detector.sv
design/lock_monitor.sv
design/loop_drive.sv
design/pfd_top.sv
tb/pfd_tb.sv
